// ==== src/csr_pkg.sv ====
package csr_pkg;

    localparam int xlen = 64;

    typedef logic [11:0] csr_addr_t;

    // machine csr addresses
    localparam csr_addr_t csr_mstatus  = 12'h300;
    localparam csr_addr_t csr_mie      = 12'h304;
    localparam csr_addr_t csr_mtvec    = 12'h305;
    localparam csr_addr_t csr_mscratch = 12'h340;
    localparam csr_addr_t csr_mepc     = 12'h341;
    localparam csr_addr_t csr_mcause   = 12'h342;
    localparam csr_addr_t csr_mtval    = 12'h343;
    localparam csr_addr_t csr_mip      = 12'h344;
    localparam csr_addr_t csr_mcycle   = 12'hb00;
    localparam csr_addr_t csr_mhartid  = 12'hf14;
    localparam csr_addr_t csr_satp     = 12'h180; // storage only

    // mstatus fields
    localparam int mstatus_mie_bit  = 3;
    localparam int mstatus_mpie_bit = 7;
    localparam int mstatus_mpp_lo   = 11;
    localparam int mstatus_mpp_hi   = 12;

    // mip lines
    localparam int mip_mtip_bit = 7;
    localparam int mip_meip_bit = 11;

    localparam logic [xlen-1:0] mstatus_mask = 64'h0000_0000_0000_1888; // mie, mpie, mpp
    localparam logic [xlen-1:0] mtvec_mask   = 64'hffff_ffff_ffff_fffd; // modes 0 and 1 only
    localparam logic [xlen-1:0] mip_mask     = 64'h0000_0000_0000_0008; // msip only

    localparam logic [5:0] cause_ecall_m = 6'd11;
    localparam logic [5:0] cause_ecall_u = 6'd8;
    localparam logic [5:0] cause_illegal = 6'd2;
    localparam logic [5:0] irq_timer     = 6'd7;
    localparam logic [5:0] irq_external  = 6'd11;

    typedef enum logic [1:0] {
        user    = 2'd0,
        machine = 2'd3
    } priv_t;

    // encodings follow funct3
    typedef enum logic [2:0] {
        none = 3'd0,
        rw   = 3'd1,
        rs   = 3'd2,
        rc   = 3'd3,
        rwi  = 3'd5,
        rsi  = 3'd6,
        rci  = 3'd7
    } csr_op_t;

    typedef enum logic [2:0] {
        ev_idle   = 3'd0,
        ev_trap   = 3'd1,
        ev_mret   = 3'd2,
        ev_write  = 3'd3,
        ev_retire = 3'd4
    } event_kind_t;

    typedef struct packed {
        logic [xlen-1:0] pc;
        csr_op_t         csr_op;
        csr_addr_t       csr_addr;
        logic [xlen-1:0] src_value; // rs1 or zero-extended uimm
        logic            src_zero;
        logic            ecall;
        logic            mret;
        logic            exc_valid;
        logic [5:0]      exc_code;
        logic [xlen-1:0] exc_tval;
    } retire_t;

    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mtvec;
        logic [xlen-1:0] mip;
        logic [xlen-1:0] mie;
        logic [xlen-1:0] mscratch;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtval;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mcycle;
        logic [xlen-1:0] mhartid;
        logic [xlen-1:0] satp;
    } csr_pack_t;

    typedef struct packed {
        logic            en;
        csr_addr_t       addr;
        logic [xlen-1:0] data;
    } csr_write_t;

    typedef struct packed {
        event_kind_t     kind;
        logic            is_interrupt;
        logic [5:0]      cause;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] tval;
        csr_write_t      wr;
    } csr_event_t;

endpackage

// ==== src/csr_access.sv ====
`timescale 1ns/1ps

module csr_access
    import csr_pkg::*;
(
    input  retire_t           retire,
    input  csr_pack_t         csrs,
    input  priv_t             priv_mode,
    output logic [xlen-1:0]   rd_value,
    output csr_write_t        wr,
    output logic              illegal
);

    logic [xlen-1:0] old_value;
    logic [xlen-1:0] new_value;
    logic            known;
    logic            writes;
    logic            is_csr;
    logic            low_priv;
    logic            read_only;

    // read mux
    always_comb begin
        old_value = '0;
        known     = 1'b1;
        unique case (retire.csr_addr)
            csr_mstatus:  old_value = csrs.mstatus;
            csr_mtvec:    old_value = csrs.mtvec;
            csr_mip:      old_value = csrs.mip;
            csr_mie:      old_value = csrs.mie;
            csr_mscratch: old_value = csrs.mscratch;
            csr_mcause:   old_value = csrs.mcause;
            csr_mtval:    old_value = csrs.mtval;
            csr_mepc:     old_value = csrs.mepc;
            csr_mcycle:   old_value = csrs.mcycle;
            csr_mhartid:  old_value = csrs.mhartid;
            csr_satp:     old_value = csrs.satp;
            default:      known = 1'b0;
        endcase
    end

    always_comb begin
        new_value = old_value;
        writes    = 1'b0;
        unique case (retire.csr_op)
            rw, rwi: begin
                new_value = retire.src_value;
                writes    = 1'b1;
            end
            rs, rsi: begin
                new_value = old_value | retire.src_value;
                writes    = !retire.src_zero; // set with x0 is a pure read
            end
            rc, rci: begin
                new_value = old_value & ~retire.src_value;
                writes    = !retire.src_zero;
            end
            default: ;
        endcase
    end

    assign is_csr    = retire.csr_op != none;
    assign low_priv  = priv_mode < retire.csr_addr[9:8]; // addr[9:8] is the lowest allowed mode
    assign read_only = retire.csr_addr[11:10] == 2'b11;

    assign illegal = is_csr && (!known || low_priv || (writes && read_only));

    assign rd_value = old_value;
    assign wr.en    = writes && !illegal;
    assign wr.addr  = retire.csr_addr;
    assign wr.data  = new_value;

endmodule

// ==== src/trap_ctrl.sv ====
`timescale 1ns/1ps

module trap_ctrl
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            retire_valid,
    input  retire_t         retire,
    input  csr_write_t      wr,
    input  logic            illegal,
    input  csr_pack_t       csrs,
    input  priv_t           priv_mode,
    output csr_event_t      evt,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc
);

    logic [xlen-1:0] pending;
    logic            irq_enabled;
    logic            take_ext;
    logic            take_timer;
    logic [xlen-1:0] trap_base;
    logic [xlen-1:0] vec_offset;
    logic [xlen-1:0] next_pc;
    logic            take_redirect;

    assign pending     = csrs.mip & csrs.mie;
    // user mode is always interruptible by machine interrupts
    assign irq_enabled = csrs.mstatus[mstatus_mie_bit] || priv_mode == user;
    assign take_ext    = irq_enabled && pending[mip_meip_bit];
    assign take_timer  = irq_enabled && pending[mip_mtip_bit];

    always_comb begin
        evt       = '0;
        evt.kind  = ev_idle;
        evt.epc   = retire.pc;
        if (retire_valid) begin
            if (take_ext || take_timer) begin
                evt.kind         = ev_trap;
                evt.is_interrupt = 1'b1;
                evt.cause        = take_ext ? irq_external : irq_timer; // external wins
            end else if (retire.exc_valid) begin
                evt.kind  = ev_trap;
                evt.cause = retire.exc_code;
                evt.tval  = retire.exc_tval;
            end else if (illegal || (retire.mret && priv_mode == user)) begin
                evt.kind  = ev_trap;
                evt.cause = cause_illegal;
            end else if (retire.ecall) begin
                evt.kind  = ev_trap;
                evt.cause = (priv_mode == user) ? cause_ecall_u : cause_ecall_m;
            end else if (retire.mret) begin
                evt.kind = ev_mret;
            end else if (wr.en) begin
                evt.kind = ev_write;
                evt.wr   = wr;
            end else begin
                evt.kind = ev_retire;
            end
        end
    end

    assign trap_base  = {csrs.mtvec[xlen-1:2], 2'b00};
    assign vec_offset = {{(xlen-8){1'b0}}, evt.cause, 2'b00};

    always_comb begin
        next_pc       = trap_base;
        take_redirect = 1'b0;
        if (evt.kind == ev_trap) begin
            take_redirect = 1'b1;
            if (csrs.mtvec[1:0] == 2'b01 && evt.is_interrupt)
                next_pc = trap_base + vec_offset; // vectored
        end else if (evt.kind == ev_mret) begin
            take_redirect = 1'b1;
            next_pc       = csrs.mepc;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_valid <= 1'b0;
        end else begin
            redirect_valid <= take_redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (take_redirect)
            redirect_pc <= next_pc;
    end

    // the core flushes on a redirect, so the next cycle carries no retire
    assert property (@(posedge clk) disable iff (rst) redirect_valid |=> !redirect_valid)
        else $error("redirect held for two cycles");

endmodule

// ==== src/csr_file.sv ====
`timescale 1ns/1ps

module csr_file
    import csr_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  csr_event_t evt,
    input  logic       irq_timer_line,
    input  logic       irq_ext_line,
    output csr_pack_t  csrs,
    output priv_t      priv_mode,
    output logic       mode_change
);

    logic [xlen-1:0] status_wdata;
    logic [xlen-1:0] mcycle_inc;
    priv_t           mpp_mode;

    // mpp is WARL and anything but machine reads back as user
    always_comb begin
        status_wdata = evt.wr.data & mstatus_mask;
        if (status_wdata[mstatus_mpp_hi:mstatus_mpp_lo] != machine)
            status_wdata[mstatus_mpp_hi:mstatus_mpp_lo] = user;
    end

    assign mcycle_inc = csrs.mcycle + 64'd1;
    assign mpp_mode   = priv_t'(csrs.mstatus[mstatus_mpp_hi:mstatus_mpp_lo]);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            csrs        <= '0;
            priv_mode   <= machine;
            mode_change <= 1'b0;
        end else begin
            mode_change <= 1'b0;

            unique case (evt.kind)
                ev_trap: begin
                    csrs.mstatus[mstatus_mpp_hi:mstatus_mpp_lo] <= priv_mode;
                    csrs.mstatus[mstatus_mpie_bit] <= csrs.mstatus[mstatus_mie_bit];
                    csrs.mstatus[mstatus_mie_bit]  <= 1'b0;
                    csrs.mepc   <= evt.epc;
                    csrs.mtval  <= evt.tval;
                    csrs.mcause <= {evt.is_interrupt, 57'b0, evt.cause};
                    priv_mode   <= machine;
                    mode_change <= 1'b1;
                end
                ev_mret: begin
                    csrs.mstatus[mstatus_mie_bit]  <= csrs.mstatus[mstatus_mpie_bit];
                    csrs.mstatus[mstatus_mpie_bit] <= 1'b1;
                    csrs.mstatus[mstatus_mpp_hi:mstatus_mpp_lo] <= user;
                    priv_mode   <= mpp_mode;
                    mode_change <= 1'b1;
                end
                ev_write: begin
                    if (evt.wr.addr != csr_mcycle)
                        csrs.mcycle <= mcycle_inc;
                    unique case (evt.wr.addr)
                        csr_mstatus:  csrs.mstatus  <= status_wdata;
                        csr_mtvec:    csrs.mtvec    <= evt.wr.data & mtvec_mask;
                        csr_mip:      csrs.mip      <= evt.wr.data & mip_mask;
                        csr_mie:      csrs.mie      <= evt.wr.data;
                        csr_mscratch: csrs.mscratch <= evt.wr.data;
                        csr_mcause:   csrs.mcause   <= evt.wr.data;
                        csr_mtval:    csrs.mtval    <= evt.wr.data;
                        csr_mepc:     csrs.mepc     <= evt.wr.data;
                        csr_mcycle:   csrs.mcycle   <= evt.wr.data;
                        csr_satp:     csrs.satp     <= evt.wr.data;
                        default: ; // mhartid is read-only
                    endcase
                end
                ev_retire: begin
                    csrs.mcycle <= mcycle_inc;
                end
                default: ;
            endcase

            // interrupt lines override any software write
            csrs.mip[mip_mtip_bit] <= irq_timer_line;
            csrs.mip[mip_meip_bit] <= irq_ext_line;
        end
    end

    // needs the mpp legalisation on every write path
    assert property (@(posedge clk) disable iff (rst) priv_mode inside {user, machine})
        else $error("illegal privilege mode %0d", priv_mode);

endmodule

// ==== src/csr_unit.sv ====
`timescale 1ns/1ps

module csr_unit
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            retire_valid,
    input  retire_t         retire,
    input  logic            irq_timer_line,
    input  logic            irq_ext_line,
    output logic [xlen-1:0] rd_value,
    output logic            redirect_valid,
    output logic [xlen-1:0] redirect_pc,
    output priv_t           priv_mode,
    output logic            mode_change
);

    csr_pack_t  csrs;
    csr_write_t wr;
    logic       illegal;
    csr_event_t evt;

    csr_access u_access (
        .retire    (retire),
        .csrs      (csrs),
        .priv_mode (priv_mode),
        .rd_value  (rd_value),
        .wr        (wr),
        .illegal   (illegal)
    );

    trap_ctrl u_trap (
        .clk            (clk),
        .rst            (rst),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .wr             (wr),
        .illegal        (illegal),
        .csrs           (csrs),
        .priv_mode      (priv_mode),
        .evt            (evt),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    // one update order per cycle
    csr_file u_file (
        .clk            (clk),
        .rst            (rst),
        .evt            (evt),
        .irq_timer_line (irq_timer_line),
        .irq_ext_line   (irq_ext_line),
        .csrs           (csrs),
        .priv_mode      (priv_mode),
        .mode_change    (mode_change)
    );

endmodule

// ==== dv/csr_unit_checks.sv ====
`timescale 1ns/1ps

module csr_unit_checks
    import csr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            retire_valid,
    input  retire_t         retire,
    input  logic            irq_timer_line,
    input  logic            irq_ext_line,
    input  logic [xlen-1:0] rd_value,
    input  logic            redirect_valid,
    input  logic [xlen-1:0] redirect_pc,
    input  priv_t           priv_mode,
    input  logic            mode_change,
    input  int              test_id,
    output int              errors
);

    logic [63:0] s_mstatus, s_mtvec, s_mie, s_mscratch, s_mcause, s_mtval;
    logic [63:0] s_mepc, s_mcycle, s_satp, s_mip;
    logic        s_msip, t_q, e_q;
    priv_t       s_priv;
    logic [63:0] exp_rd, wval, st_w, pend, exp_pc;
    logic        known, does_write, bad, irq_en, take_e, take_t;
    logic        exp_rv, exp_mc;
    int          err_rd, err_rv, err_pc, err_priv, err_mc;

    function automatic string test_name(input int id);
        case (id)
            1: return "writes";
            2: return "ecall";
            3: return "mret";
            4: return "interrupts";
            5: return "illegal";
            6: return "mcycle";
            default: return "reset";
        endcase
    endfunction

    always_comb begin
        s_mip     = '0;
        s_mip[3]  = s_msip;
        s_mip[7]  = t_q;
        s_mip[11] = e_q;
        known  = 1'b1;
        exp_rd = '0;
        case (retire.csr_addr)
            12'h300: exp_rd = s_mstatus;
            12'h304: exp_rd = s_mie;
            12'h305: exp_rd = s_mtvec;
            12'h340: exp_rd = s_mscratch;
            12'h341: exp_rd = s_mepc;
            12'h342: exp_rd = s_mcause;
            12'h343: exp_rd = s_mtval;
            12'h344: exp_rd = s_mip;
            12'hb00: exp_rd = s_mcycle;
            12'hf14: exp_rd = '0; // single hart
            12'h180: exp_rd = s_satp;
            default: known = 1'b0;
        endcase
        does_write = 1'b0;
        wval       = exp_rd;
        case (retire.csr_op)
            rw, rwi: begin
                does_write = 1'b1;
                wval       = retire.src_value;
            end
            rs, rsi: begin
                does_write = !retire.src_zero;
                wval       = exp_rd | retire.src_value;
            end
            rc, rci: begin
                does_write = !retire.src_zero;
                wval       = exp_rd & ~retire.src_value;
            end
            default: ;
        endcase
        // every implemented CSR needs more than user privilege
        bad = retire.csr_op != none
            && (!known || s_priv == user || (does_write && retire.csr_addr == 12'hf14));
        st_w = wval & 64'h1888;
        if (st_w[12:11] != 2'b11)
            st_w[12:11] = 2'b00;
        pend   = s_mip & s_mie;
        irq_en = s_mstatus[3] || s_priv == user;
        take_e = irq_en && pend[11];
        take_t = irq_en && pend[7];
    end

    task automatic take_trap(input logic intr, input logic [5:0] cause, input logic [63:0] tval);
        logic [63:0] base;
        base = {s_mtvec[63:2], 2'b00};
        s_mstatus[12:11] <= s_priv;
        s_mstatus[7]     <= s_mstatus[3];
        s_mstatus[3]     <= 1'b0;
        s_mepc   <= retire.pc;
        s_mtval  <= tval;
        s_mcause <= {intr, 57'b0, cause};
        s_priv   <= machine;
        exp_rv   <= 1'b1;
        exp_mc   <= 1'b1;
        exp_pc   <= (s_mtvec[1:0] == 2'b01 && intr) ? base + (64'(cause) << 2) : base;
    endtask

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {s_mstatus, s_mtvec, s_mie, s_mscratch, s_mcause} <= '0;
            {s_mtval, s_mepc, s_mcycle, s_satp, exp_pc} <= '0;
            {s_msip, t_q, e_q, exp_rv, exp_mc} <= '0;
            s_priv <= machine;
        end else begin
            t_q    <= irq_timer_line;
            e_q    <= irq_ext_line;
            exp_rv <= 1'b0;
            exp_mc <= 1'b0;
            if (retire_valid) begin
                if (take_e || take_t)
                    take_trap(1'b1, take_e ? 6'd11 : 6'd7, '0);
                else if (retire.exc_valid)
                    take_trap(1'b0, retire.exc_code, retire.exc_tval);
                else if (bad || (retire.mret && s_priv == user))
                    take_trap(1'b0, 6'd2, '0);
                else if (retire.ecall)
                    take_trap(1'b0, s_priv == user ? 6'd8 : 6'd11, '0);
                else if (retire.mret) begin
                    s_mstatus[3]     <= s_mstatus[7];
                    s_mstatus[7]     <= 1'b1;
                    s_mstatus[12:11] <= 2'b00;
                    s_priv <= priv_t'(s_mstatus[12:11]);
                    exp_rv <= 1'b1;
                    exp_mc <= 1'b1;
                    exp_pc <= s_mepc;
                end else begin
                    // a trapped instruction does not count
                    if (!(does_write && retire.csr_addr == 12'hb00))
                        s_mcycle <= s_mcycle + 64'd1;
                    if (does_write) begin
                        case (retire.csr_addr)
                            12'h300: s_mstatus  <= st_w;
                            12'h304: s_mie      <= wval;
                            12'h305: s_mtvec    <= wval & ~64'h2;
                            12'h340: s_mscratch <= wval;
                            12'h341: s_mepc     <= wval;
                            12'h342: s_mcause   <= wval;
                            12'h343: s_mtval    <= wval;
                            12'h344: s_msip     <= wval[3];
                            12'hb00: s_mcycle   <= wval;
                            12'h180: s_satp     <= wval;
                            default: ;
                        endcase
                    end
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        retire_valid && retire.csr_op != none |-> rd_value == exp_rd)
    else begin
        err_rd++;
        $display("FAILED %s: rd_value expected %h actual %h", test_name(test_id),
            $sampled(exp_rd), $sampled(rd_value));
    end

    assert property (@(posedge clk) disable iff (rst) redirect_valid == exp_rv)
    else begin
        err_rv++;
        $display("FAILED %s: redirect_valid expected %0b actual %0b", test_name(test_id),
            $sampled(exp_rv), $sampled(redirect_valid));
    end

    assert property (@(posedge clk) disable iff (rst) exp_rv |-> redirect_pc == exp_pc)
    else begin
        err_pc++;
        $display("FAILED %s: redirect_pc expected %h actual %h", test_name(test_id),
            $sampled(exp_pc), $sampled(redirect_pc));
    end

    assert property (@(posedge clk) disable iff (rst) priv_mode == s_priv)
    else begin
        err_priv++;
        $display("FAILED %s: priv_mode expected %0d actual %0d", test_name(test_id),
            $sampled(s_priv), $sampled(priv_mode));
    end

    assert property (@(posedge clk) disable iff (rst) mode_change == exp_mc)
    else begin
        err_mc++;
        $display("FAILED %s: mode_change expected %0b actual %0b", test_name(test_id),
            $sampled(exp_mc), $sampled(mode_change));
    end

    initial begin
        err_rd   = 0;
        err_rv   = 0;
        err_pc   = 0;
        err_priv = 0;
        err_mc   = 0;
    end

    assign errors = err_rd + err_rv + err_pc + err_priv + err_mc;

endmodule

// ==== dv/csr_unit_tb.sv ====
`timescale 1ns/1ps

module csr_unit_tb
    import csr_pkg::*;
;

    localparam int num_retires = 200;
    localparam int timeout_ns  = num_retires * 2 * 4 + 400; // two cycles per retire

    logic            clk;
    logic            rst;
    logic            retire_valid;
    retire_t         retire;
    logic            irq_timer_line;
    logic            irq_ext_line;
    logic [xlen-1:0] rd_value;
    logic            redirect_valid;
    logic [xlen-1:0] redirect_pc;
    priv_t           priv_mode;
    logic            mode_change;
    int              test_id;
    int              errors;
    int              seed;
    logic [63:0]     pc_next;

    csr_addr_t writable[9] = '{csr_mstatus, csr_mtvec, csr_mip, csr_mie, csr_mscratch,
                               csr_mcause, csr_mtval, csr_mepc, csr_satp};

    csr_unit DUT (.*);

    csr_unit_checks u_checks (.*);

    always #2 clk = ~clk;

    initial begin
        #(timeout_ns * 1ns);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic retire_one(input retire_t r);
        @(posedge clk);
        r.pc = pc_next;
        pc_next = pc_next + 64'd4;
        retire_valid <= 1'b1;
        retire       <= r;
        @(posedge clk);
        retire_valid <= 1'b0; // idle cycle while the redirect shows
    endtask

    // reads on consecutive cycles with no idle between them
    task automatic read_burst(input csr_addr_t addr, input int count);
        retire_t r;
        r          = '0;
        r.csr_op   = rs;
        r.csr_addr = addr;
        r.src_zero = 1'b1;
        @(posedge clk);
        repeat (count) begin
            r.pc    = pc_next;
            pc_next = pc_next + 64'd4;
            retire_valid <= 1'b1;
            retire       <= r;
            @(posedge clk);
        end
        retire_valid <= 1'b0;
    endtask

    task automatic csr_op(input csr_op_t op, input csr_addr_t addr, input logic [63:0] val);
        retire_t r;
        r           = '0;
        r.csr_op    = op;
        r.csr_addr  = addr;
        r.src_value = val;
        r.src_zero  = val == 0;
        retire_one(r);
    endtask

    task automatic read_csr(input csr_addr_t addr);
        csr_op(rs, addr, '0);
    endtask

    task automatic plain(input logic ecall, input logic mret);
        retire_t r;
        r       = '0;
        r.ecall = ecall;
        r.mret  = mret;
        retire_one(r);
    endtask

    function automatic logic [63:0] rand64();
        return {$random(seed), $random(seed)};
    endfunction

    task automatic write_tests();
        logic [63:0] imm;
        test_id = 1;
        foreach (writable[i]) begin
            csr_op(rw, writable[i], rand64());
            read_csr(writable[i]);
            csr_op(rs, writable[i], rand64());
            read_csr(writable[i]);
            csr_op(rc, writable[i], rand64());
            read_csr(writable[i]);
            imm = 64'($random(seed) & 32'h1f);
            csr_op(rwi, writable[i], imm);
            imm = 64'($random(seed) & 32'h1f);
            csr_op(rsi, writable[i], imm);
            imm = 64'($random(seed) & 32'h1f);
            csr_op(rci, writable[i], imm);
            read_csr(writable[i]);
            csr_op(rs, writable[i], '0); // src_zero so no write
            read_csr(writable[i]);
        end
        csr_op(rw, csr_mstatus, '0);
        csr_op(rw, csr_mie, '0);
        csr_op(rw, csr_mip, '0);
    endtask

    task automatic trap_tests();
        test_id = 2;
        csr_op(rw, csr_mtvec, 64'h1000);
        csr_op(rw, csr_mstatus, 64'h8);
        plain(1'b1, 1'b0); // ecall from machine
        read_csr(csr_mepc);
        read_csr(csr_mcause);
        read_csr(csr_mstatus);
        csr_op(rw, csr_mepc, 64'h200);
        csr_op(rw, csr_mstatus, 64'h80);
        plain(1'b0, 1'b1); // drop to user
        plain(1'b1, 1'b0); // ecall from user
        read_csr(csr_mepc);
        read_csr(csr_mcause);
        read_csr(csr_mstatus);
        test_id = 3;
        csr_op(rw, csr_mstatus, 64'h1880);
        csr_op(rw, csr_mepc, 64'h300);
        plain(1'b0, 1'b1);
        read_csr(csr_mstatus);
    endtask

    task automatic irq_tests();
        test_id = 4;
        csr_op(rw, csr_mstatus, '0);
        csr_op(rw, csr_mtvec, 64'h1001);
        csr_op(rw, csr_mie, 64'h80);
        irq_timer_line <= 1'b1;
        plain(1'b0, 1'b0); // masked by mstatus.mie
        csr_op(rs, csr_mstatus, 64'h8);
        plain(1'b0, 1'b0); // traps to base + 28
        irq_timer_line <= 1'b0;
        read_csr(csr_mcause);
        csr_op(rw, csr_mie, 64'h880);
        irq_timer_line <= 1'b1;
        irq_ext_line   <= 1'b1;
        csr_op(rs, csr_mstatus, 64'h8);
        plain(1'b0, 1'b0); // external before timer
        irq_timer_line <= 1'b0;
        irq_ext_line   <= 1'b0;
        read_csr(csr_mcause);
        csr_op(rw, csr_mie, '0);
        csr_op(rw, csr_mtvec, 64'h1000);
    endtask

    task automatic illegal_tests();
        test_id = 5;
        csr_op(rw, csr_mhartid, 64'h5);
        read_csr(csr_mcause);
        read_csr(csr_mhartid);
        csr_op(rw, csr_mstatus, '0);
        csr_op(rw, csr_mepc, 64'h500);
        plain(1'b0, 1'b1);
        csr_op(rs, csr_mstatus, 64'h8); // user access
        read_csr(csr_mstatus);
        csr_op(rw, csr_mepc, 64'h600);
        plain(1'b0, 1'b1);
        plain(1'b0, 1'b1); // mret in user
        read_csr(csr_mcause);
        read_csr(csr_mepc);
    endtask

    task automatic mcycle_tests();
        test_id = 6;
        read_csr(csr_mcycle);
        repeat (5) plain(1'b0, 1'b0);
        read_csr(csr_mcycle);
        csr_op(rw, csr_mcycle, 64'h1234);
        read_csr(csr_mcycle);
        read_csr(csr_mcycle);
        read_burst(csr_mcycle, 4); // each read sees the count left by the one before
    endtask

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        retire_valid   = 1'b0;
        retire         = '0;
        irq_timer_line = 1'b0;
        irq_ext_line   = 1'b0;
        test_id        = 0;
        seed           = 32'hb7fbd7ca;
        pc_next        = 64'h100;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        write_tests();
        trap_tests();
        irq_tests();
        illegal_tests();
        mcycle_tests();
        repeat (3) @(posedge clk);
        $display("checks done, %0d assertion errors", errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== tb.f ====
src/csr_pkg.sv
src/csr_access.sv
src/trap_ctrl.sv
src/csr_file.sv
src/csr_unit.sv
dv/csr_unit_checks.sv
dv/csr_unit_tb.sv

// ==== Makefile ====
TOP = csr_unit_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf obj_dir
